// ==== Makefile ====
VERILATOR := verilator
TOP       := scroll_layer_tb
FLIST     := flist.f
VFLAGS    := --binary --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)

# the exit status is the search for the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/scroll_layer_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module scroll_layer_tb;

    localparam int NUM_LINES = 21;  // render_line calls over the whole run

    logic                   CLK96;
    logic                   RESET96;
    logic                   pixel_cen_i;
    logic                   hb_i;
    logic                   vb_i;
    logic                   flipx_i;
    scroll_pkg::line_t      h_i;
    scroll_pkg::line_t      vrender_i;
    scroll_pkg::scroll_t    scroll_x_i;
    scroll_pkg::scroll_t    scroll_y_i;
    scroll_pkg::vram_addr_t vram_addr_o;
    scroll_pkg::vram_word_t vram_dout_i = '0;
    logic                   gfx_cs_o;
    scroll_pkg::vram_word_t gfx_tile_o;
    scroll_pkg::gfx_offs_t  gfx_offs_o;
    logic                   gfx_ok_i = 1'b0;
    scroll_pkg::gfx_word_t  gfx_data_i = '0;
    scroll_pkg::pixel_t     pixel_o;
    logic                   render_busy_o;

    integer seed = 32'hb1ee58da;
    int errors = 0;
    int gfx_errors = 0;  // counted by the ROM model
    int err_mark = 0;
    int tests_run = 0;
    int pixels_checked = 0;
    int lines_done = 0;
    int gfx_wait = 0;
    int delay_tab [256];
    logic [7:0] delay_idx = '0;
    logic req_open = 1'b0;
    logic exp_valid = 1'b0;
    scroll_pkg::vram_word_t vram [2048];
    scroll_pkg::vram_addr_t vram_last = '0;
    scroll_pkg::pixel_t exp_cur [scroll_pkg::SCREEN_W];
    scroll_pkg::pixel_t exp_prev [scroll_pkg::SCREEN_W];

    tb_clock u_clock (.CLK96(CLK96), .RESET96(RESET96));

    scroll_layer u_dut (.*);

    task automatic check_pixel(input int x, input scroll_pkg::pixel_t got,
                               input scroll_pkg::pixel_t exp);
        if (got !== exp) begin
            errors++;
            $display("error pixel_o at x=%0d: got %h expected %h", x, got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error render_busy_o: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_addr(input scroll_pkg::vram_addr_t got,
                              input scroll_pkg::vram_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("error vram_addr_o: got %h expected %h", got, exp);
        end
    endtask

    // hashed ROM contents, roughly one nibble in eight is zero
    function automatic scroll_pkg::gfx_word_t gfx_mix(input scroll_pkg::vram_word_t tile,
                                                      input scroll_pkg::gfx_offs_t offs);
        logic [31:0] h;
        scroll_pkg::gfx_word_t w;
        h = {tile, 11'd0, offs} * 32'h9e3779b1;
        h = h ^ (h >> 13);
        for (int k = 0; k < 8; k++) begin
            w[4*k +: 4] = h[4*k+1 +: 3] == 3'd0 ? 4'h0 : h[4*k +: 4];
        end
        return w;
    endfunction

    function automatic int map_row(input scroll_pkg::line_t v, input scroll_pkg::scroll_t sy);
        return ((int'(v) + (int'(sy) & 15)) / 16 + (int'(sy) >>> 4)) & 31;
    endfunction

    // word address of the attribute for scan column c
    function automatic int map_word(input int row, input scroll_pkg::scroll_t sx, input int c);
        return row * 64 + (((int'(sx) >>> 4) + c) & 31) * 2;
    endfunction

    task automatic build_expected(input scroll_pkg::line_t v, input scroll_pkg::scroll_t sx,
                                  input scroll_pkg::scroll_t sy, input logic flip);
        int a;
        int x;
        int lit;
        scroll_pkg::vram_word_t attr;
        scroll_pkg::vram_word_t tile;
        scroll_pkg::gfx_word_t w;
        logic [3:0] code;
        lit = (int'(v) + (int'(sy) & 15)) & 15;
        for (int i = 0; i < scroll_pkg::SCREEN_W; i++) exp_cur[i] = '0;
        // low levels first so higher ones paint over them
        for (int p = 0; p < scroll_pkg::NUM_PRIO; p++) begin
            for (int c = 0; c < scroll_pkg::MAP_COLS_VISIBLE; c++) begin
                a    = map_word(map_row(v, sy), sx, c);
                attr = vram[a];
                tile = vram[a + 1];
                if (tile != '0 && int'(attr[11:8]) == p) begin
                    for (int half = 0; half < 2; half++) begin
                        w = gfx_mix(tile, scroll_pkg::gfx_offs_t'(lit * 2 + half));
                        for (int k = 0; k < 8; k++) begin
                            code = w[4*k +: 4];
                            x    = c * 16 - (int'(sx) & 15) + half * 8 + k;
                            if (code != 4'h0 && x >= 0 && x < scroll_pkg::SCREEN_W)
                                exp_cur[flip ? 319 - x : x] = {attr[11:8], attr[6:0], code};
                        end
                    end
                end
            end
        end
    endtask

    task automatic fill_map(input logic blank);
        for (int a = 0; a < 2048; a += 2) begin
            vram[a]     = 16'($random(seed));
            vram[a + 1] = (blank || $unsigned($random(seed)) % 3 == 0) ? 16'h0
                                                                         : 16'($random(seed));
        end
    endtask

    task automatic fill_delays(input int max_wait);
        for (int i = 0; i < 256; i++) delay_tab[i] = 1 + int'($unsigned($random(seed)) % max_wait);
    endtask

    task automatic read_line();
        for (int x = 0; x < scroll_pkg::SCREEN_W; x++) begin
            h_i         = scroll_pkg::line_t'(x);
            pixel_cen_i = 1'b1;
            @(negedge CLK96);
            pixel_cen_i = 1'b0;
            if (exp_valid) begin
                check_pixel(x, pixel_o, exp_prev[x]);
                pixels_checked++;
            end
            @(negedge CLK96);
        end
    endtask

    // start one line, read out the previous one, wait for the render to end
    task automatic render_line(input logic flip, input logic gated);
        scroll_pkg::line_t v;
        int n;
        v          = scroll_pkg::line_t'($unsigned($random(seed)) % 240);
        vrender_i  = v;
        scroll_x_i = scroll_pkg::scroll_t'($random(seed));
        scroll_y_i = scroll_pkg::scroll_t'($random(seed));
        flipx_i    = flip;
        build_expected(v, scroll_x_i, scroll_y_i, flip);
        hb_i = 1'b0;
        n    = 0;
        while (!render_busy_o && n < 100) begin
            @(negedge CLK96);
            n++;
        end
        if (!render_busy_o) begin
            errors++;
            $display("line start on line %0d never raised render_busy_o", lines_done);
        end else begin
            check_addr(vram_addr_o, scroll_pkg::vram_addr_t'(
                       map_word(map_row(v, scroll_y_i), scroll_x_i, 0) + 1));
        end
        if (gated) begin
            hb_i      = 1'b1;
            vrender_i = v ^ 9'h0a5;  // would change the row if it were taken
            repeat (3) @(negedge CLK96);
            hb_i = 1'b0;
            repeat (3) @(negedge CLK96);
            check_busy(render_busy_o, 1'b1);
        end
        read_line();
        n = 0;
        while (render_busy_o && n < 20000) begin
            @(negedge CLK96);
            n++;
        end
        if (render_busy_o) begin
            errors++;
            $display("render of line %0d did not finish", lines_done);
        end
        hb_i = 1'b1;
        repeat (4) @(negedge CLK96);
        exp_prev  = exp_cur;
        exp_valid = lines_done >= 2;  // lines 0 and 1 are warm-up
        lines_done++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors + gfx_errors - err_mark);
        err_mark = errors + gfx_errors;
    endtask

    // tile RAM answers one cycle after the address
    always @(negedge CLK96) begin
        vram_dout_i = vram[vram_last];
        vram_last   = vram_addr_o;
    end

    // graphics ROM with a random answer delay
    always @(negedge CLK96) begin
        if (gfx_ok_i) begin
            gfx_ok_i = 1'b0;
            req_open = 1'b0;
        end else if (gfx_cs_o) begin
            if (!req_open) begin
                req_open  = 1'b1;
                gfx_wait  = delay_tab[delay_idx];
                delay_idx = delay_idx + 8'd1;
            end
            gfx_wait = gfx_wait - 1;
            if (gfx_wait == 0) begin
                gfx_ok_i   = 1'b1;
                gfx_data_i = gfx_mix(gfx_tile_o, gfx_offs_o);
            end
        end else if (req_open) begin
            gfx_errors++;
            $display("gfx_cs_o dropped before gfx_ok_i answered the request");
        end
    end

    initial begin
        #(NUM_LINES * 20000);
        $display("watchdog expired, the run took longer than %0d lines allow", NUM_LINES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        pixel_cen_i = 1'b0;
        hb_i        = 1'b1;
        vb_i        = 1'b0;
        flipx_i     = 1'b0;
        h_i         = '0;
        vrender_i   = '0;
        scroll_x_i  = '0;
        scroll_y_i  = '0;
        fill_delays(6);
        fill_map(1'b0);
        @(negedge RESET96);
        repeat (2) @(negedge CLK96);
        check_busy(render_busy_o, 1'b0);
        check_pixel(0, pixel_o, '0);
        repeat (20) begin
            if (gfx_cs_o !== 1'b0) begin
                errors++;
                $display("graphics request seen before the first line start");
            end
            @(negedge CLK96);
        end
        finish_test("reset");
        repeat (6) render_line(1'b0, 1'b0);
        finish_test("normal render");
        repeat (4) render_line(1'b1, 1'b0);  // same map, mirrored
        finish_test("flip");
        fill_map(1'b1);
        repeat (4) render_line(1'b0, 1'b0);
        finish_test("blank and transparent");
        fill_map(1'b0);
        fill_delays(24);
        repeat (4) render_line(1'b0, 1'b0);
        finish_test("graphics back-pressure");
        fill_delays(6);
        render_line(1'b0, 1'b1);
        render_line(1'b1, 1'b0);
        render_line(1'b0, 1'b0);  // reads out the last rendered line
        finish_test("busy gating");
        $display("%0d tests, %0d pixels checked, %0d errors",
                 tests_run, pixels_checked, errors + gfx_errors);
        if (errors + gfx_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic CLK96,
    output logic RESET96
);

    localparam int HALF_PERIOD  = 5;   // 10 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        CLK96 = 1'b0;
        forever #HALF_PERIOD CLK96 = ~CLK96;
    end

    initial begin
        RESET96 = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK96);
        @(negedge CLK96);  // release away from the active edge
        RESET96 = 1'b0;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
src/scroll_pkg.sv
src/line_buffer.sv
src/priority_queue.sv
src/tile_scanner.sv
src/tile_renderer.sv
src/scroll_layer.sv
dv/tb_clock.sv
dv/scroll_layer_tb.sv

// ==== src/line_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
    input  wire logic               CLK96,
    input  wire logic               swap_i,
    input  wire logic               we_i,
    input  wire scroll_pkg::line_t  wr_addr_i,
    input  wire scroll_pkg::pixel_t wr_data_i,
    input  wire logic               rd_en_i,
    input  wire scroll_pkg::line_t  rd_addr_i,
    output scroll_pkg::pixel_t      rd_data_o
);

    scroll_pkg::pixel_t mem [2][scroll_pkg::SCREEN_W];
    logic wr_bank = 1'b0;  // display reads the other bank

    always_ff @(posedge CLK96) begin
        if (swap_i) begin
            wr_bank <= ~wr_bank;
        end
        if (we_i) begin
            mem[wr_bank][wr_addr_i] <= wr_data_i;
        end
        // clear behind the beam so the bank starts empty next line
        if (rd_en_i) begin
            mem[~wr_bank][rd_addr_i] <= '0;
        end
    end

    assign rd_data_o = mem[~wr_bank][rd_addr_i];

    // renderer clipping must keep writes on screen
    a_wr_in_range : assert property (@(posedge CLK96)
        we_i |-> wr_addr_i < scroll_pkg::SCREEN_W);

endmodule

`default_nettype wire

// ==== src/priority_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module priority_queue (
    input  wire logic                   CLK96,
    input  wire logic                   RESET96,
    input  wire logic                   clear_i,
    input  wire logic                   push_i,
    input  wire scroll_pkg::prio_t      push_prio_i,
    input  wire scroll_pkg::vram_word_t push_tile_i,
    input  wire logic [6:0]             push_pal_i,
    input  wire logic [4:0]             push_col_i,
    input  wire logic [4:0]             rd_idx_i,
    output scroll_pkg::vram_word_t      rd_tile_o,
    output logic [6:0]                  rd_pal_o,
    output logic [4:0]                  rd_col_o,
    output scroll_pkg::prio_t           low_prio_o,
    output logic [4:0]                  low_count_o,
    output logic                        any_pending_o,
    input  wire logic                   retire_i
);

    localparam int ENTRIES = scroll_pkg::NUM_PRIO * scroll_pkg::QUEUE_DEPTH;

    logic [27:0] mem [ENTRIES];  // {tile, palette, column}
    logic [scroll_pkg::NUM_PRIO-1:0][4:0] count;
    logic [scroll_pkg::NUM_PRIO-1:0]      pending;
    scroll_pkg::queue_addr_t wr_addr;
    scroll_pkg::queue_addr_t rd_addr;
    logic [27:0] rd_q;

    function automatic scroll_pkg::queue_addr_t slot(scroll_pkg::prio_t prio, logic [4:0] idx);
        return scroll_pkg::queue_addr_t'(prio) *
               scroll_pkg::queue_addr_t'(scroll_pkg::QUEUE_DEPTH) +
               scroll_pkg::queue_addr_t'(idx);
    endfunction

    assign wr_addr = slot(push_prio_i, count[push_prio_i]);
    assign rd_addr = slot(low_prio_o, rd_idx_i);

    // lowest level still waiting to be drawn
    always_comb begin
        low_prio_o = '0;
        for (int p = scroll_pkg::NUM_PRIO - 1; p >= 0; p--) begin
            if (pending[p]) low_prio_o = scroll_pkg::prio_t'(p);
        end
    end

    assign low_count_o   = count[low_prio_o];
    assign any_pending_o = |pending;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            count   <= '0;
            pending <= '0;
        end else if (clear_i) begin
            count   <= '0;
            pending <= '0;
        end else begin
            if (push_i) begin
                count[push_prio_i]   <= count[push_prio_i] + 5'd1;
                pending[push_prio_i] <= 1'b1;
            end
            if (retire_i) begin
                pending[low_prio_o] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (push_i) begin
            mem[wr_addr] <= {push_tile_i, push_pal_i, push_col_i};
        end
        rd_q <= mem[rd_addr];  // one cycle read latency
    end

    assign rd_tile_o = rd_q[27:12];
    assign rd_pal_o  = rd_q[11:5];
    assign rd_col_o  = rd_q[4:0];

    // scanner visits 21 columns per line, so a level can never overflow
    a_no_overflow : assert property (@(posedge CLK96) disable iff (RESET96)
        push_i |-> count[push_prio_i] < scroll_pkg::QUEUE_DEPTH);

endmodule

`default_nettype wire

// ==== src/scroll_layer.sv ====
`timescale 1ns/1ns
`default_nettype none

module scroll_layer (
    input  wire logic                   CLK96,
    input  wire logic                   RESET96,
    input  wire logic                   pixel_cen_i,
    input  wire logic                   hb_i,
    input  wire logic                   vb_i,
    input  wire logic                   flipx_i,
    input  wire scroll_pkg::line_t      h_i,
    input  wire scroll_pkg::line_t      vrender_i,
    input  wire scroll_pkg::scroll_t    scroll_x_i,
    input  wire scroll_pkg::scroll_t    scroll_y_i,
    output scroll_pkg::vram_addr_t      vram_addr_o,
    input  wire scroll_pkg::vram_word_t vram_dout_i,
    output logic                        gfx_cs_o,
    output scroll_pkg::vram_word_t      gfx_tile_o,
    output scroll_pkg::gfx_offs_t       gfx_offs_o,
    input  wire logic                   gfx_ok_i,
    input  wire scroll_pkg::gfx_word_t  gfx_data_i,
    output scroll_pkg::pixel_t          pixel_o,
    output logic                        render_busy_o
);

    logic hb_d;
    logic start_q;  // one cycle, clears queue and swaps banks

    logic                   scan_push;
    scroll_pkg::prio_t      scan_prio;
    scroll_pkg::vram_word_t scan_tile;
    logic [6:0]             scan_pal;
    logic [4:0]             scan_col;
    logic [3:0]             line_in_tile;
    logic                   scan_done;

    logic [4:0]             q_rd_idx;
    scroll_pkg::vram_word_t q_rd_tile;
    logic [6:0]             q_rd_pal;
    logic [4:0]             q_rd_col;
    scroll_pkg::prio_t      q_low_prio;
    logic [4:0]             q_low_count;
    logic                   q_any;
    logic                   q_retire;

    logic               buf_we;
    scroll_pkg::line_t  buf_addr;
    scroll_pkg::pixel_t buf_data;
    logic               rd_en;
    scroll_pkg::pixel_t rd_data;
    logic               render_done;

    assign rd_en = pixel_cen_i && !hb_i;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            hb_d          <= 1'b0;
            start_q       <= 1'b0;
            render_busy_o <= 1'b0;
            pixel_o       <= '0;
        end else begin
            hb_d    <= hb_i;
            start_q <= hb_d && !hb_i && !vb_i && !render_busy_o;  // late starts dropped
            if (start_q) begin
                render_busy_o <= 1'b1;
            end else if (render_done) begin
                render_busy_o <= 1'b0;
            end
            if (rd_en) pixel_o <= rd_data;
        end
    end

    tile_scanner u_scanner (
        .CLK96         (CLK96),
        .RESET96       (RESET96),
        .start_i       (start_q),
        .vrender_i     (vrender_i),
        .scroll_x_i    (scroll_x_i),
        .scroll_y_i    (scroll_y_i),
        .vram_addr_o   (vram_addr_o),
        .vram_dout_i   (vram_dout_i),
        .push_o        (scan_push),
        .push_prio_o   (scan_prio),
        .push_tile_o   (scan_tile),
        .push_pal_o    (scan_pal),
        .push_col_o    (scan_col),
        .line_in_tile_o(line_in_tile),
        .done_o        (scan_done)
    );

    priority_queue u_queue (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .clear_i      (start_q),
        .push_i       (scan_push),
        .push_prio_i  (scan_prio),
        .push_tile_i  (scan_tile),
        .push_pal_i   (scan_pal),
        .push_col_i   (scan_col),
        .rd_idx_i     (q_rd_idx),
        .rd_tile_o    (q_rd_tile),
        .rd_pal_o     (q_rd_pal),
        .rd_col_o     (q_rd_col),
        .low_prio_o   (q_low_prio),
        .low_count_o  (q_low_count),
        .any_pending_o(q_any),
        .retire_i     (q_retire)
    );

    tile_renderer u_renderer (
        .CLK96         (CLK96),
        .RESET96       (RESET96),
        .scan_done_i   (scan_done),
        .line_in_tile_i(line_in_tile),
        .scroll_x_i    (scroll_x_i),
        .flipx_i       (flipx_i),
        .rd_idx_o      (q_rd_idx),
        .rd_tile_i     (q_rd_tile),
        .rd_pal_i      (q_rd_pal),
        .rd_col_i      (q_rd_col),
        .low_prio_i    (q_low_prio),
        .low_count_i   (q_low_count),
        .any_pending_i (q_any),
        .retire_o      (q_retire),
        .gfx_cs_o      (gfx_cs_o),
        .gfx_tile_o    (gfx_tile_o),
        .gfx_offs_o    (gfx_offs_o),
        .gfx_ok_i      (gfx_ok_i),
        .gfx_data_i    (gfx_data_i),
        .buf_we_o      (buf_we),
        .buf_addr_o    (buf_addr),
        .buf_data_o    (buf_data),
        .done_o        (render_done)
    );

    line_buffer u_linebuf (
        .CLK96    (CLK96),
        .swap_i   (start_q),
        .we_i     (buf_we),
        .wr_addr_i(buf_addr),
        .wr_data_i(buf_data),
        .rd_en_i  (rd_en),
        .rd_addr_i(h_i),
        .rd_data_o(rd_data)
    );

    // a bank swap mid render would tear the line
    a_start_idle : assert property (@(posedge CLK96) disable iff (RESET96)
        start_q |-> !render_busy_o);

endmodule

`default_nettype wire

// ==== src/scroll_pkg.sv ====
`default_nettype none

package scroll_pkg;

    localparam int SCREEN_W         = 320;
    localparam int MAP_COLS_VISIBLE = 21;
    localparam int TILE_SIZE        = 16;
    localparam int NUM_PRIO         = 16;
    localparam int QUEUE_DEPTH      = 21;  // one full row can land on a single level

    typedef logic [14:0]        pixel_t;      // prio 14:11, palette 10:4, code 3:0
    typedef logic [10:0]        vram_addr_t;  // {map row, map col, word select}
    typedef logic [15:0]        vram_word_t;
    typedef logic signed [12:0] scroll_t;
    typedef logic [8:0]         line_t;
    typedef logic [31:0]        gfx_word_t;   // pixel k in nibble k
    typedef logic [4:0]         gfx_offs_t;   // {line in tile, half}
    typedef logic [3:0]         prio_t;
    typedef logic [8:0]         queue_addr_t;

    // renderer FSM
    typedef enum logic [2:0] {
        RS_IDLE,
        RS_PICK,
        RS_WAIT,
        RS_FETCH,
        RS_DRAW,
        RS_NEXT
    } render_state_e;

endpackage

`default_nettype wire

// ==== src/tile_renderer.sv ====
`timescale 1ns/1ns
`default_nettype none

module tile_renderer (
    input  wire logic                   CLK96,
    input  wire logic                   RESET96,
    input  wire logic                   scan_done_i,
    input  wire logic [3:0]             line_in_tile_i,
    input  wire scroll_pkg::scroll_t    scroll_x_i,
    input  wire logic                   flipx_i,
    output logic [4:0]                  rd_idx_o,
    input  wire scroll_pkg::vram_word_t rd_tile_i,
    input  wire logic [6:0]             rd_pal_i,
    input  wire logic [4:0]             rd_col_i,
    input  wire scroll_pkg::prio_t      low_prio_i,
    input  wire logic [4:0]             low_count_i,
    input  wire logic                   any_pending_i,
    output logic                        retire_o,
    output logic                        gfx_cs_o,
    output scroll_pkg::vram_word_t      gfx_tile_o,
    output scroll_pkg::gfx_offs_t       gfx_offs_o,
    input  wire logic                   gfx_ok_i,
    input  wire scroll_pkg::gfx_word_t  gfx_data_i,
    output logic                        buf_we_o,
    output scroll_pkg::line_t           buf_addr_o,
    output scroll_pkg::pixel_t          buf_data_o,
    output logic                        done_o
);

    scroll_pkg::render_state_e state;
    scroll_pkg::gfx_word_t     data_q;
    logic [4:0] idx_q;
    logic       half_q;
    logic [2:0] k_q;     // pixel within the half row
    logic [3:0] code;
    logic [9:0] base;    // screen x before fine scroll
    logic [9:0] fine;
    logic [9:0] px;
    logic       visible;
    logic       last_tile;

    assign code    = data_q[{k_q, 2'b00} +: 4];
    assign fine    = 10'(scroll_x_i[3:0]);
    assign base    = 10'(rd_col_i) * 10'(scroll_pkg::TILE_SIZE) + {6'b0, half_q, 3'b0} +
                     10'(k_q);
    assign px      = base - fine;
    assign visible = base >= fine && px < 10'(scroll_pkg::SCREEN_W);

    // queue outputs stay put until the level is retired
    assign rd_idx_o  = idx_q;
    assign last_tile = idx_q + 5'd1 == low_count_i;
    assign retire_o  = state == scroll_pkg::RS_NEXT && half_q && last_tile;
    assign done_o    = state == scroll_pkg::RS_PICK && !any_pending_i;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state      <= scroll_pkg::RS_IDLE;
            idx_q      <= '0;
            half_q     <= 1'b0;
            k_q        <= '0;
            gfx_cs_o   <= 1'b0;
            gfx_tile_o <= '0;
            gfx_offs_o <= '0;
            buf_we_o   <= 1'b0;
            buf_addr_o <= '0;
            buf_data_o <= '0;
        end else begin
            buf_we_o <= 1'b0;
            case (state)
                scroll_pkg::RS_IDLE: begin
                    if (scan_done_i) state <= scroll_pkg::RS_PICK;
                end
                scroll_pkg::RS_PICK: begin
                    idx_q  <= '0;
                    half_q <= 1'b0;
                    state  <= any_pending_i ? scroll_pkg::RS_WAIT : scroll_pkg::RS_IDLE;
                end
                scroll_pkg::RS_WAIT: state <= scroll_pkg::RS_FETCH;  // queue read latency
                scroll_pkg::RS_FETCH: begin
                    if (!gfx_cs_o) begin
                        gfx_cs_o   <= 1'b1;
                        gfx_tile_o <= rd_tile_i;
                        gfx_offs_o <= {line_in_tile_i, half_q};
                    end else if (gfx_ok_i) begin
                        gfx_cs_o <= 1'b0;
                        k_q      <= '0;
                        state    <= scroll_pkg::RS_DRAW;
                    end
                end
                scroll_pkg::RS_DRAW: begin
                    buf_we_o   <= code != '0 && visible;  // zero code is transparent
                    buf_addr_o <= flipx_i ? scroll_pkg::line_t'(scroll_pkg::SCREEN_W - 1) - px[8:0]
                                          : px[8:0];
                    buf_data_o <= {low_prio_i, rd_pal_i, code};
                    k_q        <= k_q + 3'd1;
                    if (k_q == 3'd7) state <= scroll_pkg::RS_NEXT;
                end
                scroll_pkg::RS_NEXT: begin
                    if (!half_q) begin
                        half_q <= 1'b1;
                        state  <= scroll_pkg::RS_FETCH;
                    end else begin
                        half_q <= 1'b0;
                        idx_q  <= idx_q + 5'd1;
                        state  <= last_tile ? scroll_pkg::RS_PICK : scroll_pkg::RS_WAIT;
                    end
                end
                default: state <= scroll_pkg::RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state == scroll_pkg::RS_FETCH && gfx_cs_o && gfx_ok_i) begin
            data_q <= gfx_data_i;
        end
    end

    // ROM request held until it is answered
    a_gfx_hold : assert property (@(posedge CLK96) disable iff (RESET96)
        gfx_cs_o && !gfx_ok_i |=> gfx_cs_o && $stable(gfx_tile_o) && $stable(gfx_offs_o));

endmodule

`default_nettype wire

// ==== src/tile_scanner.sv ====
`timescale 1ns/1ns
`default_nettype none

module tile_scanner (
    input  wire logic                   CLK96,
    input  wire logic                   RESET96,
    input  wire logic                   start_i,
    input  wire scroll_pkg::line_t      vrender_i,
    input  wire scroll_pkg::scroll_t    scroll_x_i,
    input  wire scroll_pkg::scroll_t    scroll_y_i,
    output scroll_pkg::vram_addr_t      vram_addr_o,
    input  wire scroll_pkg::vram_word_t vram_dout_i,
    output logic                        push_o,
    output scroll_pkg::prio_t           push_prio_o,
    output scroll_pkg::vram_word_t      push_tile_o,
    output logic [6:0]                  push_pal_o,
    output logic [4:0]                  push_col_o,
    output logic [3:0]                  line_in_tile_o,
    output logic                        done_o
);

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_NUM,   // tile number address out
        SC_ATTR,  // attribute address out, tile number back
        SC_PUSH   // attribute back
    } scan_state_e;

    scan_state_e            state;
    logic [4:0]             row_q;
    logic [4:0]             col_q;
    logic [4:0]             map_col;
    scroll_pkg::line_t      y_sum;
    scroll_pkg::vram_word_t tile_q;
    logic                   last_col;

    assign y_sum    = vrender_i + scroll_pkg::line_t'(scroll_y_i[3:0]);
    assign map_col  = scroll_x_i[8:4] + col_q;  // wraps at 32
    assign last_col = col_q == 5'(scroll_pkg::MAP_COLS_VISIBLE - 1);

    // odd word is the tile number, even word the attributes
    assign vram_addr_o = {row_q, map_col, state == SC_NUM};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state          <= SC_IDLE;
            row_q          <= '0;
            col_q          <= '0;
            line_in_tile_o <= '0;
        end else if (start_i) begin
            state          <= SC_NUM;
            row_q          <= y_sum[8:4] + scroll_y_i[8:4];
            col_q          <= '0;
            line_in_tile_o <= y_sum[3:0];
        end else begin
            case (state)
                SC_NUM:  state <= SC_ATTR;
                SC_ATTR: state <= SC_PUSH;
                SC_PUSH: begin
                    col_q <= col_q + 5'd1;
                    state <= last_col ? SC_IDLE : SC_NUM;
                end
                default: state <= SC_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state == SC_ATTR) begin
            tile_q <= vram_dout_i;
        end
    end

    assign push_o      = state == SC_PUSH && tile_q != '0;  // tile 0 is blank
    assign push_prio_o = vram_dout_i[11:8];
    assign push_pal_o  = vram_dout_i[6:0];
    assign push_tile_o = tile_q;
    assign push_col_o  = col_q;
    assign done_o      = state == SC_PUSH && last_col;

endmodule

`default_nettype wire
